//--- logic/rdp_geometry_pkg.sv
// *************************************************************************
// Bus geometry of the read datapath: group, slot and word widths, and the
// per-group FIFO entry type shared by the capture FIFOs and the combiner
// *************************************************************************
`default_nettype none

package rdp_geometry_pkg;

	// Read DQS groups on the interface
	localparam int MEM_READ_DQS_WIDTH = 2;
	// DQ bits belonging to one DQS group
	localparam int DQ_GROUP_WIDTH = 4;
	localparam int MEM_DQ_WIDTH = MEM_READ_DQS_WIDTH * DQ_GROUP_WIDTH;

	// Half rate, so one AFI word carries four memory time slots
	localparam int AFI_RATE_RATIO = 2;
	localparam int NUM_TIMESLOTS = 2 * AFI_RATE_RATIO;

	// One DDIO capture beat is two slots of one group
	localparam int BEAT_WIDTH = 2 * DQ_GROUP_WIDTH;
	// Capture bus, one beat per group, group 0 in the low bits
	localparam int DDIO_PHY_DQ_WIDTH = MEM_READ_DQS_WIDTH * BEAT_WIDTH;
	localparam int AFI_DATA_WIDTH = NUM_TIMESLOTS * MEM_DQ_WIDTH;

	// One FIFO entry of one group
	// The capture side fills it a beat at a time, the read side picks it
	// apart slot by slot, so both views describe the same 16 bits
	typedef union packed {
		struct packed {
			// Second beat of the pair, slots T3 and T2
			logic [BEAT_WIDTH-1:0] neg;
			// First beat of the pair, slots T1 and T0
			logic [BEAT_WIDTH-1:0] pos;
		} beats;
		// T0 sits in the lowest bits
		logic [NUM_TIMESLOTS-1:0][DQ_GROUP_WIDTH-1:0] slots;
	} group_entry_u;

endpackage

`default_nettype wire

//--- logic/rdp_timing_pkg.sv
// *************************************************************************
// Latency and buffering constants of the read datapath, used by the
// latency shifter and the per-group capture FIFOs
// *************************************************************************
`default_nettype none

package rdp_timing_pkg;

	// Number of taps in each latency delay line
	// The sequencer picks one tap with the latency counter
	localparam int MAX_READ_LATENCY = 16;
	// Width of the latency setting, enough to address every tap
	localparam int LATENCY_COUNT_WIDTH = 4;

	// Entries held by each group FIFO
	// One entry is a full four-slot pair of beats
	localparam int READ_FIFO_DEPTH = 8;
	// Pointer width, the pointers wrap naturally at the depth
	localparam int READ_FIFO_ADDR_WIDTH = 3;

endpackage

`default_nettype wire

//--- logic/read_latency_shifter.sv
// *************************************************************************
// Delays the controller's read requests by the programmed read latency and
// gives the FIFO pop enable and the per-phase read valid from one tap
// *************************************************************************
`timescale 1ns/1ps
`default_nettype none

module read_latency_shifter
	import rdp_geometry_pkg::*;
	import rdp_timing_pkg::*;
(
	input  logic                           pll_afi_clk,
	input  logic                           reset_n_afi_clk,
	input  logic [AFI_RATE_RATIO-1:0]      afi_rdata_en_i,
	input  logic [AFI_RATE_RATIO-1:0]      afi_rdata_en_full_i,
	input  logic [LATENCY_COUNT_WIDTH-1:0] seq_read_latency_counter_i,
	output logic                           read_enable_o,
	output logic [AFI_RATE_RATIO-1:0]      read_valid_o
);

	// One delay line per AFI phase for the data valid requests
	logic [AFI_RATE_RATIO-1:0][MAX_READ_LATENCY-1:0] valid_shift;
	// One delay line for the pop request
	logic [MAX_READ_LATENCY-1:0] full_shift;
	// Any phase of the full request pops a whole entry
	logic full_req;

	assign full_req = |afi_rdata_en_full_i;

	// *********************************************************************
	// Delay lines
	// *********************************************************************

	// A request sampled at edge E sits in bit 0 after E and in bit k after
	// edge E+k, so bit L is the request delayed by L edges
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
		begin
			valid_shift <= '0;
			full_shift <= '0;
		end
		else
		begin
			for (int p = 0; p < AFI_RATE_RATIO; p++)
			begin
				valid_shift[p] <= {valid_shift[p][MAX_READ_LATENCY-2:0], afi_rdata_en_i[p]};
			end
			full_shift <= {full_shift[MAX_READ_LATENCY-2:0], full_req};
		end
	end

	// *********************************************************************
	// Tap selection
	// *********************************************************************

	// Both paths use the same tap, so the pop and the valid bits can never
	// drift apart whatever latency is programmed
	// The pop enable stays combinational and the FIFOs act on it at the
	// next edge
	assign read_enable_o = full_shift[seq_read_latency_counter_i];

	for (genvar p = 0; p < AFI_RATE_RATIO; p++)
	begin : g_valid_tap
		// Each phase keeps its own enable so that half-word reads show up
		// as a single valid bit
		assign read_valid_o[p] = valid_shift[p][seq_read_latency_counter_i];
	end

endmodule

`default_nettype wire

//--- logic/read_capture_fifo.sv
// *************************************************************************
// Per-group read FIFO: pairs captured beats into four-slot entries and
// hands one entry to the combiner on every pop from the latency shifter
// *************************************************************************
`timescale 1ns/1ps
`default_nettype none

module read_capture_fifo
	import rdp_geometry_pkg::*;
	import rdp_timing_pkg::*;
(
	input  logic                  pll_afi_clk,
	input  logic                  reset_n_afi_clk,
	input  logic [BEAT_WIDTH-1:0] beat_i,
	input  logic                  beat_valid_i,
	input  logic                  mem_stable_i,
	input  logic                  fifo_reset_i,
	input  logic                  read_enable_i,
	output group_entry_u          entry_o
);

	// Entry storage, filled half by half through the beats view
	group_entry_u mem [READ_FIFO_DEPTH];

	// Entry being assembled on the write side
	logic [READ_FIFO_ADDR_WIDTH-1:0] wr_ptr;
	// Next entry to hand out on a pop
	logic [READ_FIFO_ADDR_WIDTH-1:0] rd_ptr;
	// Low while the next beat is the first of a pair (slots T0 and T1)
	logic neg_beat;
	// Qualified capture strobe for this edge
	logic capture;

	// *********************************************************************
	// Write side
	// *********************************************************************

	// A beat is taken only while the sequencer reports the memory stable
	// During a pointer reset the strobe is ignored as well, so the first
	// beat after the reset is the first beat of a new pair
	assign capture = beat_valid_i && mem_stable_i && !fifo_reset_i;

	// Pairing bit and write pointer
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
		begin
			wr_ptr <= '0;
			neg_beat <= 1'b0;
		end
		else if (fifo_reset_i)
		begin
			// Held at zero for as long as the sequencer asks
			wr_ptr <= '0;
			neg_beat <= 1'b0;
		end
		else if (capture)
		begin
			neg_beat <= !neg_beat;
			// The entry is complete once its second beat is written
			if (neg_beat)
			begin
				wr_ptr <= wr_ptr + 1'b1;
			end
		end
	end

	// Storage
	// Positive beats land in the low half and negative beats in the high
	// half of the same entry, which puts T0 in the lowest slot
	always_ff @(posedge pll_afi_clk)
	begin
		if (capture)
		begin
			if (neg_beat)
			begin
				mem[wr_ptr].beats.neg <= beat_i;
			end
			else
			begin
				mem[wr_ptr].beats.pos <= beat_i;
			end
		end
	end

	// *********************************************************************
	// Read side
	// *********************************************************************

	// The pop loads the output register and advances the read pointer at
	// the same edge, so the entry is visible one edge after the pop
	// There is no empty check; the controller only asks for entries that
	// were completed before the pop
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
		begin
			rd_ptr <= '0;
			entry_o <= '0;
		end
		else
		begin
			if (fifo_reset_i)
			begin
				rd_ptr <= '0;
			end
			else if (read_enable_i)
			begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			// Output register follows every pop
			if (read_enable_i)
			begin
				entry_o <= mem[rd_ptr];
			end
		end
	end

endmodule

`default_nettype wire

//--- logic/rdata_combiner.sv
// *************************************************************************
// Maps the popped group entries into the AFI read word and the sequencer
// read word, and registers the per-phase AFI read valid bits
// *************************************************************************
`timescale 1ns/1ps
`default_nettype none

module rdata_combiner
	import rdp_geometry_pkg::*;
(
	input  logic                      pll_afi_clk,
	input  logic                      reset_n_afi_clk,
	input  group_entry_u              group_entry_i [MEM_READ_DQS_WIDTH],
	input  logic [AFI_RATE_RATIO-1:0] read_valid_i,
	output logic [AFI_DATA_WIDTH-1:0] afi_rdata_o,
	output logic [AFI_RATE_RATIO-1:0] afi_rdata_valid_o,
	output logic [AFI_DATA_WIDTH-1:0] phy_mux_read_fifo_q_o
);

	// *********************************************************************
	// Read valid
	// *********************************************************************

	// The valid bits are registered at the same edge that loads the FIFO
	// output registers, so data and valid leave the datapath together
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
		begin
			afi_rdata_valid_o <= '0;
		end
		else
		begin
			afi_rdata_valid_o <= read_valid_i;
		end
	end

	// *********************************************************************
	// Data remap
	// *********************************************************************

	// AFI order is slot-major and group-minor, from the top down
	//   G1_T3 G0_T3 G1_T2 G0_T2 G1_T1 G0_T1 G1_T0 G0_T0
	// so slot t of group g starts at t*MEM_DQ_WIDTH + g*DQ_GROUP_WIDTH
	//
	// Sequencer order is group-major and slot-minor
	//   G1_T3 G1_T2 G1_T1 G1_T0 G0_T3 G0_T2 G0_T1 G0_T0
	// which is simply each entry laid down whole, group 0 lowest
	//
	// Both words are pure wiring off the FIFO output registers
	for (genvar g = 0; g < MEM_READ_DQS_WIDTH; g++)
	begin : g_group
		for (genvar t = 0; t < NUM_TIMESLOTS; t++)
		begin : g_slot
			// Slot-major placement for the controller
			assign afi_rdata_o[t*MEM_DQ_WIDTH + g*DQ_GROUP_WIDTH +: DQ_GROUP_WIDTH] =
				group_entry_i[g].slots[t];
			// Group-major placement for calibration reads
			assign phy_mux_read_fifo_q_o[g*$bits(group_entry_u) + t*DQ_GROUP_WIDTH +:
				DQ_GROUP_WIDTH] = group_entry_i[g].slots[t];
		end
	end

endmodule

`default_nettype wire

//--- logic/read_datapath_top.sv
// *************************************************************************
// Read datapath top level in the AFI clock domain: one capture FIFO per DQS
// group, a shared latency shifter, and the output combiner
// *************************************************************************
`timescale 1ns/1ps
`default_nettype none

module read_datapath_top
	import rdp_geometry_pkg::*;
	import rdp_timing_pkg::*;
(
	input  logic                           pll_afi_clk,
	input  logic                           reset_n_afi_clk,
	input  logic [DDIO_PHY_DQ_WIDTH-1:0]   ddio_phy_dq_i,
	input  logic [MEM_READ_DQS_WIDTH-1:0]  ddio_valid_i,
	input  logic                           seq_reset_mem_stable_i,
	input  logic [MEM_READ_DQS_WIDTH-1:0]  seq_read_fifo_reset_i,
	input  logic [LATENCY_COUNT_WIDTH-1:0] seq_read_latency_counter_i,
	input  logic [AFI_RATE_RATIO-1:0]      afi_rdata_en_i,
	input  logic [AFI_RATE_RATIO-1:0]      afi_rdata_en_full_i,
	output logic [AFI_DATA_WIDTH-1:0]      afi_rdata_o,
	output logic [AFI_RATE_RATIO-1:0]      afi_rdata_valid_o,
	output logic [AFI_DATA_WIDTH-1:0]      phy_mux_read_fifo_q_o
);

	// Pop strobe shared by every group FIFO
	logic read_enable;
	// Delayed per-phase valid, registered in the combiner
	logic [AFI_RATE_RATIO-1:0] read_valid;
	// FIFO output registers, one per group
	group_entry_u group_entry [MEM_READ_DQS_WIDTH];

	// One shifter serves all groups, since all of them run on the AFI clock
	read_latency_shifter u_shifter (
		.pll_afi_clk                (pll_afi_clk),
		.reset_n_afi_clk            (reset_n_afi_clk),
		.afi_rdata_en_i             (afi_rdata_en_i),
		.afi_rdata_en_full_i        (afi_rdata_en_full_i),
		.seq_read_latency_counter_i (seq_read_latency_counter_i),
		.read_enable_o              (read_enable),
		.read_valid_o               (read_valid)
	);

	// *********************************************************************
	// Per-group capture
	// *********************************************************************

	for (genvar g = 0; g < MEM_READ_DQS_WIDTH; g++)
	begin : g_group
		// Each group takes its own beat of the capture bus, group 0 lowest
		read_capture_fifo u_fifo (
			.pll_afi_clk     (pll_afi_clk),
			.reset_n_afi_clk (reset_n_afi_clk),
			.beat_i          (ddio_phy_dq_i[g*BEAT_WIDTH +: BEAT_WIDTH]),
			.beat_valid_i    (ddio_valid_i[g]),
			.mem_stable_i    (seq_reset_mem_stable_i),
			.fifo_reset_i    (seq_read_fifo_reset_i[g]),
			.read_enable_i   (read_enable),
			.entry_o         (group_entry[g])
		);
	end

	// Bus ordering and AFI read valid
	rdata_combiner u_combiner (
		.pll_afi_clk           (pll_afi_clk),
		.reset_n_afi_clk       (reset_n_afi_clk),
		.group_entry_i         (group_entry),
		.read_valid_i          (read_valid),
		.afi_rdata_o           (afi_rdata_o),
		.afi_rdata_valid_o     (afi_rdata_valid_o),
		.phy_mux_read_fifo_q_o (phy_mux_read_fifo_q_o)
	);

endmodule

`default_nettype wire

//--- test/read_datapath_asserts.sv
// *************************************************************************
// Port-level assertions for the read datapath top level, bound to the DUT
// *************************************************************************
`timescale 1ns/1ps
`default_nettype none

module read_datapath_asserts
	import rdp_geometry_pkg::*;
	import rdp_timing_pkg::*;
(
	input logic                           pll_afi_clk,
	input logic                           reset_n_afi_clk,
	input logic [DDIO_PHY_DQ_WIDTH-1:0]   ddio_phy_dq_i,
	input logic [MEM_READ_DQS_WIDTH-1:0]  ddio_valid_i,
	input logic [LATENCY_COUNT_WIDTH-1:0] seq_read_latency_counter_i,
	input logic [AFI_RATE_RATIO-1:0]      afi_rdata_en_i,
	input logic [AFI_RATE_RATIO-1:0]      afi_rdata_valid_o
);

	// Number of assertion failures so far, read by the testbench
	int fail_count = 0;
	// Request history, entry j is the request sampled j+1 edges before now
	logic [MAX_READ_LATENCY:0][AFI_RATE_RATIO-1:0] en_hist;

	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
		begin
			en_hist <= '0;
		end
		else
		begin
			en_hist <= {en_hist[MAX_READ_LATENCY-1:0], afi_rdata_en_i};
		end
	end

	// Valid is cleared asynchronously and stays low through reset
	a_reset_valid: assert property (@(posedge pll_afi_clk)
		!reset_n_afi_clk |-> afi_rdata_valid_o == '0)
	else
	begin
		$error("afi_rdata_valid_o is set while reset is asserted");
		fail_count++;
	end

	// A strobed beat must carry known data on the capture bus
	a_known_beat: assert property (@(posedge pll_afi_clk) disable iff (!reset_n_afi_clk)
		(|ddio_valid_i) |-> !$isunknown(ddio_phy_dq_i))
	else
	begin
		$error("ddio_phy_dq_i holds unknown bits under a capture strobe");
		fail_count++;
	end

	// Every valid phase traces back to a request of that phase L+1 edges
	// before the edge that registered it
	a_valid_has_request: assert property (@(posedge pll_afi_clk) disable iff (!reset_n_afi_clk)
		(afi_rdata_valid_o & ~en_hist[int'(seq_read_latency_counter_i) + 1]) == '0)
	else
	begin
		$error("afi_rdata_valid_o is set without a matching read request");
		fail_count++;
	end

endmodule

bind read_datapath_top read_datapath_asserts u_asserts (
	.pll_afi_clk                (pll_afi_clk),
	.reset_n_afi_clk            (reset_n_afi_clk),
	.ddio_phy_dq_i              (ddio_phy_dq_i),
	.ddio_valid_i               (ddio_valid_i),
	.seq_read_latency_counter_i (seq_read_latency_counter_i),
	.afi_rdata_en_i             (afi_rdata_en_i),
	.afi_rdata_valid_o          (afi_rdata_valid_o)
);

`default_nettype wire

//--- test/read_datapath_tb.sv
// *************************************************************************
// Testbench for the read datapath: seeded random captures and reads, checked
// every cycle against a queue model of the group FIFOs and both bus orders
// *************************************************************************
`timescale 1ns/1ps
`default_nettype none

module read_datapath_tb
	import rdp_geometry_pkg::*;
	import rdp_timing_pkg::*;
();

	localparam int SEED = 9651;
	localparam int CLK_PERIOD = 4;
	localparam int RESET_CYCLES = 5;
	localparam int NUM_ROUNDS = 6;
	// Worst case of one round: 16 beats with gaps, 8 reads with gaps, the
	// last word, and a full pass through the delay lines
	localparam int ROUND_CYCLES = 96;
	localparam int TEST_CYCLES = RESET_CYCLES + (NUM_ROUNDS + 1) * ROUND_CYCLES;
	localparam int CYCLE_LIMIT = TEST_CYCLES + 200;

	logic                           pll_afi_clk;
	logic                           reset_n_afi_clk;
	logic [DDIO_PHY_DQ_WIDTH-1:0]   ddio_phy_dq_i;
	logic [MEM_READ_DQS_WIDTH-1:0]  ddio_valid_i;
	logic                           seq_reset_mem_stable_i;
	logic [MEM_READ_DQS_WIDTH-1:0]  seq_read_fifo_reset_i;
	logic [LATENCY_COUNT_WIDTH-1:0] seq_read_latency_counter_i;
	logic [AFI_RATE_RATIO-1:0]      afi_rdata_en_i;
	logic [AFI_RATE_RATIO-1:0]      afi_rdata_en_full_i;
	logic [AFI_DATA_WIDTH-1:0]      afi_rdata_o;
	logic [AFI_RATE_RATIO-1:0]      afi_rdata_valid_o;
	logic [AFI_DATA_WIDTH-1:0]      phy_mux_read_fifo_q_o;

	// Rising edges seen so far
	int edge_cnt = 0;
	// Latency currently programmed into the DUT
	logic [LATENCY_COUNT_WIDTH-1:0] lat;
	// Captured beats per group, oldest first
	logic [BEAT_WIDTH-1:0] beat_q [MEM_READ_DQS_WIDTH][$];
	// Expected reads, each tagged with the edge after which it shows
	int exp_due [$];
	logic [AFI_DATA_WIDTH-1:0] exp_afi [$];
	logic [AFI_DATA_WIDTH-1:0] exp_seq [$];
	logic [AFI_RATE_RATIO-1:0] exp_valid [$];

	read_datapath_top dut0 (.*);

	initial
	begin
		pll_afi_clk = 1'b0;
		forever #(CLK_PERIOD / 2) pll_afi_clk = ~pll_afi_clk;
	end

	// *********************************************************************
	// Checks
	// *********************************************************************

	task automatic check_value(input string what, input logic [AFI_DATA_WIDTH-1:0] expected,
		input logic [AFI_DATA_WIDTH-1:0] actual);
		if (actual !== expected)
		begin
			$display("FAILED at %0t ns: %s expected %h, got %h", $time, what, expected, actual);
			$display("SIMULATION FAILED");
			$fatal(1);
		end
	endtask

	// Outputs are compared mid-cycle, well away from the edge that moves them
	task automatic check_outputs();
		logic [AFI_RATE_RATIO-1:0] valid;
		valid = '0;
		if (dut0.u_asserts.fail_count != 0)
		begin
			$display("A port assertion on the DUT failed at %0t ns", $time);
			$display("SIMULATION FAILED");
			$fatal(1);
		end
		if (exp_due.size() != 0 && exp_due[0] == edge_cnt)
		begin
			void'(exp_due.pop_front());
			valid = exp_valid.pop_front();
			check_value("afi_rdata_o", exp_afi.pop_front(), afi_rdata_o);
			check_value("phy_mux_read_fifo_q_o", exp_seq.pop_front(), phy_mux_read_fifo_q_o);
		end
		check_value("afi_rdata_valid_o", valid, afi_rdata_valid_o);
	endtask

	always @(negedge pll_afi_clk)
	begin
		if (reset_n_afi_clk)
		begin
			check_outputs();
		end
	end

	// Edge counter, which also bounds the run
	always @(posedge pll_afi_clk)
	begin
		edge_cnt <= edge_cnt + 1;
		if (edge_cnt >= CYCLE_LIMIT)
		begin
			$display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("SIMULATION FAILED");
			$fatal(1);
		end
	end

	// *********************************************************************
	// Stimulus
	// *********************************************************************

	task automatic next_cycle();
		@(posedge pll_afi_clk);
		#1;
	endtask

	task automatic drive_idle();
		next_cycle();
		ddio_valid_i = '0;
		seq_reset_mem_stable_i = 1'b1;
		afi_rdata_en_i = '0;
		afi_rdata_en_full_i = '0;
	endtask

	// Strobes random beats into the masked groups; the model keeps only the
	// beats that a stable memory and a released pointer reset let through
	task automatic drive_capture(input logic [MEM_READ_DQS_WIDTH-1:0] mask, input logic stable);
		next_cycle();
		afi_rdata_en_i = '0;
		afi_rdata_en_full_i = '0;
		seq_reset_mem_stable_i = stable;
		ddio_valid_i = mask;
		ddio_phy_dq_i = DDIO_PHY_DQ_WIDTH'($urandom);
		for (int g = 0; g < MEM_READ_DQS_WIDTH; g++)
		begin
			if (mask[g] && stable && !seq_read_fifo_reset_i[g])
			begin
				beat_q[g].push_back(ddio_phy_dq_i[g*BEAT_WIDTH +: BEAT_WIDTH]);
			end
		end
	endtask

	// One read request, with the word it must return L+2 edges later
	task automatic drive_read(input logic [AFI_RATE_RATIO-1:0] en,
		input logic [AFI_RATE_RATIO-1:0] full);
		logic [BEAT_WIDTH-1:0] pos;
		logic [BEAT_WIDTH-1:0] neg;
		logic [DQ_GROUP_WIDTH-1:0] slot;
		logic [AFI_DATA_WIDTH-1:0] afi_word;
		logic [AFI_DATA_WIDTH-1:0] seq_word;
		next_cycle();
		ddio_valid_i = '0;
		afi_rdata_en_i = en;
		afi_rdata_en_full_i = full;
		afi_word = '0;
		seq_word = '0;
		for (int g = 0; g < MEM_READ_DQS_WIDTH; g++)
		begin
			pos = beat_q[g].pop_front();
			neg = beat_q[g].pop_front();
			for (int t = 0; t < NUM_TIMESLOTS; t++)
			begin
				// T0 and T1 arrive in the first beat, low nibble first
				slot = (t < 2) ? pos[(t%2)*DQ_GROUP_WIDTH +: DQ_GROUP_WIDTH] :
					neg[(t%2)*DQ_GROUP_WIDTH +: DQ_GROUP_WIDTH];
				afi_word[t*MEM_DQ_WIDTH + g*DQ_GROUP_WIDTH +: DQ_GROUP_WIDTH] = slot;
				seq_word[g*NUM_TIMESLOTS*DQ_GROUP_WIDTH + t*DQ_GROUP_WIDTH +: DQ_GROUP_WIDTH] = slot;
			end
		end
		exp_due.push_back(edge_cnt + int'(lat) + 2);
		exp_afi.push_back(afi_word);
		exp_seq.push_back(seq_word);
		exp_valid.push_back(en);
	endtask

	task automatic capture_entries(input int n);
		for (int i = 0; i < 2 * n; i++)
		begin
			if ($urandom % 4 == 0)
			begin
				drive_idle();
			end
			drive_capture('1, 1'b1);
		end
	endtask

	// Reads with short random gaps, so that several are in flight at once
	task automatic read_entries(input int n);
		for (int i = 0; i < n; i++)
		begin
			drive_read(AFI_RATE_RATIO'(1 + $urandom % 3), AFI_RATE_RATIO'(1 + $urandom % 3));
			repeat ($urandom % 3) drive_idle();
		end
	endtask

	// Waits for every expected word, then lets the delay lines run empty
	// so that a longer latency cannot pick up an old request
	task automatic wait_drained();
		while (exp_due.size() != 0)
		begin
			drive_idle();
		end
		repeat (MAX_READ_LATENCY) drive_idle();
	endtask

	initial
	begin
		int n;
		void'($urandom(SEED));
		reset_n_afi_clk = 1'b0;
		ddio_phy_dq_i = '0;
		ddio_valid_i = '0;
		seq_reset_mem_stable_i = 1'b1;
		seq_read_fifo_reset_i = '0;
		seq_read_latency_counter_i = '0;
		afi_rdata_en_i = '0;
		afi_rdata_en_full_i = '0;
		lat = '0;
		repeat (RESET_CYCLES) @(posedge pll_afi_clk);
		#1;
		reset_n_afi_clk = 1'b1;
		drive_idle();
		check_value("afi_rdata_o after reset", '0, afi_rdata_o);
		check_value("phy_mux_read_fifo_q_o after reset", '0, phy_mux_read_fifo_q_o);
		check_value("afi_rdata_valid_o after reset", '0, afi_rdata_valid_o);

		// Fixed latency first, then random ones, the last at the longest tap
		for (int r = 0; r < NUM_ROUNDS; r++)
		begin
			next_cycle();
			lat = (r == 0) ? 3 : (r == NUM_ROUNDS - 1) ? MAX_READ_LATENCY - 1 :
				LATENCY_COUNT_WIDTH'($urandom % MAX_READ_LATENCY);
			seq_read_latency_counter_i = lat;
			n = 1 + $urandom % READ_FIFO_DEPTH;
			capture_entries(n);
			read_entries(n);
			wait_drained();
		end

		// Strobes during unstable memory, then a partial group 1 discarded
		repeat (4) drive_capture('1, 1'b0);
		repeat (3) drive_capture(2'b10, 1'b1);
		next_cycle();
		ddio_valid_i = '0;
		seq_read_fifo_reset_i[1] = 1'b1;
		beat_q[1].delete();
		next_cycle();
		seq_read_fifo_reset_i = '0;
		capture_entries(2);
		read_entries(2);
		wait_drained();

		if (dut0.u_asserts.fail_count != 0)
		begin
			$display("A port assertion on the DUT failed during the run");
			$display("SIMULATION FAILED");
			$fatal(1);
		end
		else
		begin
			$display("SIMULATION PASSED");
			$finish;
		end
	end

endmodule

`default_nettype wire

//--- build.f
logic/rdp_geometry_pkg.sv
logic/rdp_timing_pkg.sv
logic/read_latency_shifter.sv
logic/read_capture_fifo.sv
logic/rdata_combiner.sv
logic/read_datapath_top.sv
test/read_datapath_asserts.sv
test/read_datapath_tb.sv
